//--- logic/add_align.sv
`include "fp_add_defs.svh"

module add_align import fp_add_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       in_valid,
   input  fp_req_t    req,
   output logic       s1_valid,
   output align_res_t align
);

   // Internal width adds a round bit below the guard bit.
   localparam int WW = `SUM_WIDTH + 1;

   logic                    sign_a;
   logic                    sign_b;
   logic [`EXP_WIDTH-1:0]   exp_a;
   logic [`EXP_WIDTH-1:0]   exp_b;
   logic [`MAN_WIDTH-1:0]   frac_a;
   logic [`MAN_WIDTH-1:0]   frac_b;
   logic                    b_is_big;
   logic                    sign_big;
   logic [`EXP_WIDTH-1:0]   exp_big;
   logic [`EXP_WIDTH-1:0]   exp_small;
   logic [`EXP_WIDTH-1:0]   exp_diff;
   logic [`MAN_WIDTH:0]     sig_big;
   logic [`MAN_WIDTH:0]     sig_small;
   logic [4:0]              shamt;
   logic [2*WW-1:0]         shift_ext;
   logic [WW-1:0]           big_ext;
   logic [WW-1:0]           small_ext;
   logic                    eff_sub;
   logic [WW:0]             sum_wide;
   logic [`SUM_WIDTH-1:0]   sum_frac;
   logic [`EXP_WIDTH-1:0]   sum_exp;

   always_comb begin
      sign_a = req.operand_a[`FP_WIDTH-1];
      sign_b = req.operand_b[`FP_WIDTH-1] ^ (req.op == op_sub);
      exp_a  = req.operand_a[`FP_WIDTH-2 -: `EXP_WIDTH];
      exp_b  = req.operand_b[`FP_WIDTH-2 -: `EXP_WIDTH];

      // Subnormal operands count as zero.
      frac_a = (exp_a == '0) ? '0 : req.operand_a[`MAN_WIDTH-1:0];
      frac_b = (exp_b == '0) ? '0 : req.operand_b[`MAN_WIDTH-1:0];

      b_is_big  = {exp_b, frac_b} > {exp_a, frac_a};
      sign_big  = b_is_big ? sign_b : sign_a;
      exp_big   = b_is_big ? exp_b : exp_a;
      exp_small = b_is_big ? exp_a : exp_b;
      sig_big   = b_is_big ? {exp_b != '0, frac_b} : {exp_a != '0, frac_a};
      sig_small = b_is_big ? {exp_a != '0, frac_a} : {exp_b != '0, frac_b};
      eff_sub   = sign_a ^ sign_b;

      exp_diff = exp_big - exp_small;
      shamt    = (exp_diff > 8'd31) ? 5'd31 : exp_diff[4:0];   // Beyond 27 all is sticky.
   end

   always_comb begin
      big_ext   = {sig_big, {(WW - `MAN_WIDTH - 1){1'b0}}};
      shift_ext = {sig_small, {(WW - `MAN_WIDTH - 1){1'b0}}, {WW{1'b0}}} >> shamt;

      // Every bit shifted past the round bit is folded into the sticky bit.
      small_ext = {shift_ext[2*WW-1:WW+1], shift_ext[WW] | (|shift_ext[WW-1:0])};

      if (eff_sub) begin
         sum_wide = {1'b0, big_ext} - {1'b0, small_ext};   // Larger first, so no borrow.
      end else begin
         sum_wide = {1'b0, big_ext} + {1'b0, small_ext};
      end

      if (sum_wide[WW] || sum_wide[WW-1]) begin
         sum_frac = {sum_wide[WW-1:2], sum_wide[1] | sum_wide[0]};
         sum_exp  = exp_big;
      end else begin
         // The top bit cancelled. Moving up one place now keeps the round bit.
         sum_frac = sum_wide[WW-2:0];
         sum_exp  = exp_big - 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         s1_valid <= 1'b0;
      end else begin
         s1_valid <= in_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (in_valid) begin
         align.sign      <= sign_big;
         align.exp_max   <= sum_exp;
         align.sum_frac  <= sum_frac;
         align.carry_out <= sum_wide[WW];
         align.frm       <= req.frm;
      end
   end

endmodule

//--- logic/add_normalize_round.sv
`include "fp_add_defs.svh"

module add_normalize_round import fp_add_pkg::*; (
   input  logic         clk,
   input  logic         rst_n,
   input  logic         s1_valid,
   input  align_res_t   align,
   input  special_res_t special,
   output logic         out_valid,
   output fp_res_t      res
);

   logic [4:0]              lzc;
   logic [`SUM_WIDTH-1:0]   norm_frac;
   logic [`EXP_WIDTH:0]     exp_pre;
   logic [`MAN_WIDTH-1:0]   mant;
   logic                    guard;
   logic                    sticky;
   logic                    round_up;
   logic [`FP_WIDTH-2:0]    rounded;
   logic                    sum_zero;
   logic                    ovf;
   logic                    unf;
   fp_res_t                 res_d;

   // Leading zero count of the sum. The highest set bit is the last one seen.
   always_comb begin
      lzc = '0;
      for (int i = 0; i < `SUM_WIDTH; i++) begin
         if (align.sum_frac[i]) begin
            lzc = 5'(`SUM_WIDTH - 1 - i);
         end
      end
   end

   always_comb begin
      sum_zero  = (align.sum_frac == '0) && !align.carry_out;
      norm_frac = align.sum_frac << lzc;
      unf       = 1'b0;

      if (align.carry_out) begin
         // The carry becomes the hidden bit, one place up.
         mant    = align.sum_frac[`SUM_WIDTH-1 -: `MAN_WIDTH];
         guard   = align.sum_frac[2];
         sticky  = |align.sum_frac[1:0];
         exp_pre = {1'b0, align.exp_max} + 1'b1;
      end else begin
         mant    = norm_frac[`SUM_WIDTH-2 -: `MAN_WIDTH];
         guard   = norm_frac[1];
         sticky  = norm_frac[0];
         exp_pre = {1'b0, align.exp_max} - {4'b0, lzc};
         unf     = !sum_zero && ({3'b0, lzc} >= align.exp_max);   // Exponent would be 0 or less.
      end
   end

   always_comb begin
      case (align.frm)
         rm_rne:  round_up = guard && (sticky || mant[0]);
         rm_rtz:  round_up = 1'b0;
         rm_rdn:  round_up = align.sign && (guard || sticky);
         rm_rup:  round_up = !align.sign && (guard || sticky);
         rm_rmm:  round_up = guard;
         default: round_up = 1'b0;
      endcase

      // A carry out of the fraction lands in the exponent and renormalizes.
      rounded = {exp_pre[`EXP_WIDTH-1:0], mant} + {{(`FP_WIDTH-2){1'b0}}, round_up};

      ovf = !unf && ((exp_pre >= (`EXP_WIDTH+1)'(`EXP_MAX)) ||
                     (rounded[`FP_WIDTH-2 -: `EXP_WIDTH] == `EXP_WIDTH'(`EXP_MAX)));
   end

   always_comb begin
      res_d.flags = '0;
      if (special.inv) begin
         res_d.value    = `QNAN;
         res_d.flags.nv = 1'b1;
      end else if (special.is_inf) begin
         res_d.value = {special.inf_sign, `INF_MAG};
      end else if (special.is_zero_exact) begin
         res_d.value = {special.zero_sign, {(`FP_WIDTH-1){1'b0}}};
      end else if (special.pass_a || special.pass_b) begin
         res_d.value = special.pass_value;
      end else if (sum_zero) begin
         // Exact cancellation is +0 unless rounding down.
         res_d.value = {align.frm == rm_rdn, {(`FP_WIDTH-1){1'b0}}};
      end else if (ovf) begin
         res_d.value    = {align.sign, `INF_MAG};   // Infinity in every rounding mode.
         res_d.flags.of = 1'b1;
         res_d.flags.nx = 1'b1;
      end else if (unf) begin
         res_d.value    = {align.sign, {(`FP_WIDTH-1){1'b0}}};
         res_d.flags.uf = 1'b1;
         res_d.flags.nx = 1'b1;
      end else begin
         res_d.value    = {align.sign, rounded};
         res_d.flags.nx = guard || sticky;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
         res.flags <= '0;
      end else begin
         out_valid <= s1_valid;
         if (s1_valid) begin
            res <= res_d;
         end
      end
   end

endmodule

//--- logic/add_special.sv
`include "fp_add_defs.svh"

module add_special import fp_add_pkg::*; (
   input  logic         clk,
   input  logic         rst_n,
   input  logic         in_valid,
   input  fp_req_t      req,
   output special_res_t special
);

   logic                    sign_a;
   logic                    sign_b;
   logic [`EXP_WIDTH-1:0]   exp_a;
   logic [`EXP_WIDTH-1:0]   exp_b;
   logic                    a_nan;
   logic                    b_nan;
   logic                    a_inf;
   logic                    b_inf;
   logic                    a_zero;
   logic                    b_zero;
   logic                    a_finite_nz;
   logic                    b_finite_nz;
   special_res_t            special_d;

   always_comb begin
      sign_a = req.operand_a[`FP_WIDTH-1];
      sign_b = req.operand_b[`FP_WIDTH-1] ^ (req.op == op_sub);   // Effective sign.
      exp_a  = req.operand_a[`FP_WIDTH-2 -: `EXP_WIDTH];
      exp_b  = req.operand_b[`FP_WIDTH-2 -: `EXP_WIDTH];

      a_nan  = (exp_a == `EXP_WIDTH'(`EXP_MAX)) && (req.operand_a[`MAN_WIDTH-1:0] != '0);
      b_nan  = (exp_b == `EXP_WIDTH'(`EXP_MAX)) && (req.operand_b[`MAN_WIDTH-1:0] != '0);
      a_inf  = (exp_a == `EXP_WIDTH'(`EXP_MAX)) && (req.operand_a[`MAN_WIDTH-1:0] == '0);
      b_inf  = (exp_b == `EXP_WIDTH'(`EXP_MAX)) && (req.operand_b[`MAN_WIDTH-1:0] == '0);
      a_zero = (exp_a == '0);                    // Subnormals land here too.
      b_zero = (exp_b == '0);

      a_finite_nz = !a_zero && (exp_a != `EXP_WIDTH'(`EXP_MAX));
      b_finite_nz = !b_zero && (exp_b != `EXP_WIDTH'(`EXP_MAX));
   end

   always_comb begin
      special_d.inv      = a_nan || b_nan || (a_inf && b_inf && (sign_a != sign_b));
      special_d.is_inf   = !special_d.inv && (a_inf || b_inf);
      special_d.inf_sign = a_inf ? sign_a : sign_b;   // Both infinite means equal signs.

      // Two zeros give -0 only when both are negative or the sum rounds down.
      special_d.is_zero_exact = a_zero && b_zero;
      special_d.zero_sign     = (sign_a && sign_b) ||
                                ((sign_a != sign_b) && (req.frm == rm_rdn));

      special_d.pass_b     = a_zero && b_finite_nz;
      special_d.pass_a     = b_zero && a_finite_nz;
      special_d.pass_value = a_zero ? {sign_b, req.operand_b[`FP_WIDTH-2:0]}
                                    : req.operand_a;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         special.inv           <= 1'b0;
         special.is_inf        <= 1'b0;
         special.is_zero_exact <= 1'b0;
         special.pass_b        <= 1'b0;
         special.pass_a        <= 1'b0;
      end else if (in_valid) begin
         special <= special_d;
      end
   end

endmodule

//--- logic/fp_add_defs.svh
`ifndef FP_ADD_DEFS_SVH
`define FP_ADD_DEFS_SVH

// Single precision field layout.
`define FP_WIDTH   32
`define EXP_WIDTH  8
`define MAN_WIDTH  23

`define EXP_BIAS   127            // Exponent of 1.0 in biased form.
`define EXP_MAX    255            // Biased exponent of infinity and NaN.

// Canonical quiet NaN returned for every invalid operation.
`define QNAN       32'h7FC0_0000

// Magnitude bits of infinity, to be prefixed with a sign.
`define INF_MAG    31'h7F80_0000

// Aligned sum width is the hidden bit, the fraction, a guard bit and a sticky bit.
`define SUM_WIDTH  26

`endif

//--- logic/fp_add_pkg.sv
`include "fp_add_defs.svh"

package fp_add_pkg;

   typedef enum logic {
      op_add = 1'b0,
      op_sub = 1'b1                              // Sign of b is inverted.
   } fp_op_e;

   typedef enum logic [2:0] {
      rm_rne = 3'd0,                             // Nearest, ties to even.
      rm_rtz = 3'd1,                             // Toward zero.
      rm_rdn = 3'd2,                             // Toward minus infinity.
      rm_rup = 3'd3,                             // Toward plus infinity.
      rm_rmm = 3'd4                              // Nearest, ties away from zero.
   } round_mode_e;

   typedef struct packed {
      fp_op_e                 op;
      round_mode_e            frm;
      logic [`FP_WIDTH-1:0]   operand_a;
      logic [`FP_WIDTH-1:0]   operand_b;
   } fp_req_t;

   typedef struct packed {
      logic                   sign;              // Sign of the larger operand.
      logic [`EXP_WIDTH-1:0]  exp_max;           // Exponent that goes with sum_frac bit 25.
      logic [`SUM_WIDTH-1:0]  sum_frac;
      logic                   carry_out;
      round_mode_e            frm;
   } align_res_t;

   typedef struct packed {
      logic                   inv;
      logic                   is_inf;
      logic                   inf_sign;
      logic                   is_zero_exact;
      logic                   zero_sign;
      logic                   pass_b;            // Operand a is zero.
      logic                   pass_a;            // Operand b is zero.
      logic [`FP_WIDTH-1:0]   pass_value;
   } special_res_t;

   typedef struct packed {
      logic nv;
      logic of;
      logic uf;
      logic nx;
   } fp_flags_t;

   typedef struct packed {
      logic [`FP_WIDTH-1:0]   value;
      fp_flags_t              flags;
   } fp_res_t;

endpackage

//--- logic/fp_add_unit.sv
module fp_add_unit import fp_add_pkg::*; (
   input  logic    clk,
   input  logic    rst_n,
   input  logic    in_valid,
   input  fp_req_t req,
   output logic    out_valid,
   output fp_res_t res
);

   logic         s1_valid;                       // Stage one holds a request.
   align_res_t   s1_align;                       // Aligned and added significands.
   special_res_t s1_special;                     // Special case decisions for the same request.

   // Both first-stage blocks capture the same request on the same edge.
   add_align u_add_align (
      .clk      (clk),
      .rst_n    (rst_n),
      .in_valid (in_valid),
      .req      (req),
      .s1_valid (s1_valid),
      .align    (s1_align)
   );

   add_special u_add_special (
      .clk      (clk),
      .rst_n    (rst_n),
      .in_valid (in_valid),
      .req      (req),
      .special  (s1_special)
   );

   add_normalize_round u_add_normalize_round (
      .clk       (clk),
      .rst_n     (rst_n),
      .s1_valid  (s1_valid),
      .align     (s1_align),
      .special   (s1_special),
      .out_valid (out_valid),
      .res       (res)
   );

endmodule

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the log.
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module fp_add_tb \
   -Mdir obj_dir -o fp_add_sim > build.log 2>&1 \
   && ./obj_dir/fp_add_sim +verilator+error+limit+100 > sim.log 2>&1 \
   || { echo "Build or simulation did not complete"; cat build.log sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "^>>> PASS$" sim.log && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }

//--- sim.f
+incdir+logic
logic/fp_add_pkg.sv
logic/add_align.sv
logic/add_special.sv
logic/add_normalize_round.sv
logic/fp_add_unit.sv
tb/tb_clock.sv
tb/fp_add_checker.sv
tb/fp_add_tb.sv

//--- tb/fp_add_checker.sv
`include "fp_add_defs.svh"

module fp_add_checker import fp_add_pkg::*; (
   input logic    clk,
   input logic    rst_n,
   input logic    in_valid,
   input logic    out_valid,
   input fp_res_t res
);

   int unsigned n_fail = 0;                      // Assertion failures so far.

   // Two clean edges out of reset are needed before the pipeline is defined.
   a_latency: assert property (@(posedge clk) disable iff (!rst_n)
      ($past(rst_n) && $past(rst_n, 2)) |-> (out_valid == $past(in_valid, 2)))
      else begin
         n_fail++;
         $error("out_valid does not follow in_valid by two cycles");
      end

   a_reset_idle: assert property (@(posedge clk) !rst_n |=> !out_valid)
      else begin
         n_fail++;
         $error("out_valid is high while reset is applied");
      end

   a_nv_qnan: assert property (@(posedge clk) disable iff (!rst_n)
      (out_valid && res.flags.nv) |-> (res.value == `QNAN))
      else begin
         n_fail++;
         $error("Invalid flag raised with a value other than the quiet NaN");
      end

   a_of_nx: assert property (@(posedge clk) disable iff (!rst_n)
      (out_valid && res.flags.of) |-> res.flags.nx)
      else begin
         n_fail++;
         $error("Overflow flag raised without the inexact flag");
      end

endmodule

bind fp_add_unit fp_add_checker u_fp_add_checker (
   .clk       (clk),
   .rst_n     (rst_n),
   .in_valid  (in_valid),
   .out_valid (out_valid),
   .res       (res)
);

//--- tb/fp_add_tb.sv
`include "fp_add_defs.svh"

module fp_add_tb import fp_add_pkg::*; ();

   localparam int RESET_CYCLES   = 16;
   localparam int N_RAND         = 200;
   localparam int N_CANCEL       = 40;
   localparam int N_OVUF         = 24;
   localparam int N_NAN          = 8;
   localparam int N_ZERO         = 16;
   localparam int N_BURST        = 40;
   localparam int N_TOTAL        = N_RAND + N_CANCEL + N_OVUF + N_NAN + N_ZERO + N_BURST;
   localparam int TIMEOUT_CYCLES = N_TOTAL + 50;

   logic        clk;
   logic        rst_n;
   logic        in_valid;
   fp_req_t     req;
   logic        out_valid;
   fp_res_t     res;
   fp_req_t     req_q[$];                        // Requests still waiting for a result.
   int unsigned sent_q[$];                       // Cycle in which each request was driven.
   logic [31:0] lcg_state = 32'd25;
   int unsigned cycle = 0;
   int          n_checks = 0;
   int          n_errors = 0;

   tb_clock #(.PERIOD(8)) u_tb_clock (.clk(clk));

   fp_add_unit u_fp_add_unit (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .req       (req),
      .out_valid (out_valid),
      .res       (res)
   );

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   function automatic round_mode_e rand_frm();
      return round_mode_e'(3'((lcg_next() >> 8) % 5));
   endfunction

   function automatic logic [31:0] rand_normal(input int lo, input int span);
      logic [31:0] x;
      logic [31:0] y;
      x = lcg_next();
      y = lcg_next();
      return {x[31], 8'(lo + int'((y >> 8) % span)), x[22:0]};
   endfunction

   // Zero, subnormal or normal operand, picked by kind.
   function automatic logic [31:0] edge_operand(input logic [1:0] kind);
      logic [31:0] x;
      x = lcg_next();
      case (kind)
         2'd0:    return {x[31], 31'b0};
         2'd2:    return rand_normal(110, 30);
         default: return {x[31], 8'd0, x[22:0]};
      endcase
   endfunction

   // Exact sum in a 64-bit window, then one correct rounding.
   function automatic fp_res_t fp_add_ref(input fp_req_t r);
      fp_res_t     o;
      logic        sa;
      logic        sb;
      logic        sbig;
      logic [7:0]  ea;
      logic [7:0]  eb;
      logic [7:0]  ebig;
      logic [7:0]  diff;
      logic [22:0] fa;
      logic [22:0] fb;
      logic [63:0] wbig;
      logic [63:0] wsml;
      logic [63:0] w;
      logic [63:0] rem;
      logic [63:0] half;
      logic [24:0] m;
      logic        g;
      logic        s;
      logic        up;
      int          p;
      int          e;
      int          sh;
      o  = '0;
      sa = r.operand_a[31];
      sb = r.operand_b[31] ^ (r.op == op_sub);
      ea = r.operand_a[30:23];
      eb = r.operand_b[30:23];
      fa = (ea == 8'd0) ? 23'd0 : r.operand_a[22:0];
      fb = (eb == 8'd0) ? 23'd0 : r.operand_b[22:0];
      if ((ea == 8'd255 && fa != 0) || (eb == 8'd255 && fb != 0) ||
          (ea == 8'd255 && eb == 8'd255 && sa != sb)) begin
         o.value    = `QNAN;
         o.flags.nv = 1'b1;
         return o;
      end
      if (ea == 8'd255 || eb == 8'd255) begin
         o.value = {(ea == 8'd255) ? sa : sb, `INF_MAG};
         return o;
      end
      if (ea == 8'd0 && eb == 8'd0) begin
         o.value = {(sa && sb) || (sa != sb && r.frm == rm_rdn), 31'b0};
         return o;
      end
      if (ea == 8'd0) begin
         o.value = {sb, r.operand_b[30:0]};
         return o;
      end
      if (eb == 8'd0) begin
         o.value = r.operand_a;
         return o;
      end
      if ({eb, fb} > {ea, fa}) begin
         sbig = sb;
         ebig = eb;
         diff = eb - ea;
         wbig = 64'({1'b1, fb}) << 38;           // Hidden bit lands on bit 61.
         wsml = 64'({1'b1, fa}) << 38;
      end else begin
         sbig = sa;
         ebig = ea;
         diff = ea - eb;
         wbig = 64'({1'b1, fa}) << 38;
         wsml = 64'({1'b1, fb}) << 38;
      end
      if (diff >= 8'd63) begin
         wsml = 64'd1;
      end else begin
         wsml = (wsml >> diff) | 64'((wsml & ((64'd1 << diff) - 1)) != 0);
      end
      w = (sa != sb) ? wbig - wsml : wbig + wsml;
      if (w == 0) begin
         o.value = {r.frm == rm_rdn, 31'b0};
         return o;
      end
      p = 63;
      while (!w[p]) p--;
      e = int'(ebig) + p - 61;
      if (e <= 0) begin
         o.value    = {sbig, 31'b0};
         o.flags.uf = 1'b1;
         o.flags.nx = 1'b1;
         return o;
      end
      sh   = p - 23;
      m    = 25'(w >> sh);
      rem  = w & ((64'd1 << sh) - 1);
      half = 64'd1 << (sh - 1);
      g    = (rem & half) != 0;
      s    = (rem & (half - 1)) != 0;
      case (r.frm)
         rm_rne:  up = g && (s || m[0]);
         rm_rdn:  up = sbig && (g || s);
         rm_rup:  up = !sbig && (g || s);
         rm_rmm:  up = g;
         default: up = 1'b0;
      endcase
      m = m + 25'(up);
      if (m[24]) begin
         m = m >> 1;
         e++;
      end
      if (e >= 255) begin
         o.value    = {sbig, `INF_MAG};
         o.flags.of = 1'b1;
         o.flags.nx = 1'b1;
         return o;
      end
      o.value    = {sbig, 8'(e), m[22:0]};
      o.flags.nx = g || s;
      return o;
   endfunction

   task automatic check_value(input fp_req_t r, input logic [`FP_WIDTH-1:0] got,
                              input logic [`FP_WIDTH-1:0] expected);
      n_checks++;
      if (got !== expected) begin
         n_errors++;
         $display("ERR %0t: %h %s %h (%s) gave value %h, expected %h", $time, r.operand_a,
                  r.op.name(), r.operand_b, r.frm.name(), got, expected);
      end
   endtask

   task automatic check_flags(input fp_req_t r, input fp_flags_t got, input fp_flags_t expected);
      n_checks++;
      if (got !== expected) begin
         n_errors++;
         $display("ERR %0t: %h %s %h (%s) gave flags %b, expected %b", $time, r.operand_a,
                  r.op.name(), r.operand_b, r.frm.name(), got, expected);
      end
   endtask

   task automatic send(input fp_op_e op, input round_mode_e frm, input logic [31:0] a,
                       input logic [31:0] b);
      @(posedge clk);
      #1;
      in_valid = 1'b1;
      req      = '{op: op, frm: frm, operand_a: a, operand_b: b};
      req_q.push_back(req);
      sent_q.push_back(cycle);
   endtask

   task automatic end_test(input string name, input int chk0, input int err0);
      @(posedge clk);
      #1;
      in_valid = 1'b0;
      while (req_q.size() != 0) @(posedge clk);
      $display("Test %s: %0d checks, %0d errors", name, n_checks - chk0, n_errors - err0);
   endtask

   always @(posedge clk) begin
      cycle <= cycle + 1;
      if (cycle > RESET_CYCLES + TIMEOUT_CYCLES) begin
         $display("Timeout after %0d cycles, %0d results never came", cycle, req_q.size());
         $display(">>> FAIL");
         $finish;
      end
   end

   // Outputs change on the rising edge, so they are read on the falling one.
   always @(negedge clk) begin
      fp_req_t     r;
      fp_res_t     expected;
      int unsigned t;
      if (!rst_n && out_valid === 1'b1) begin
         n_errors++;
         $display("out_valid is high during reset at time %0t", $time);
      end else if (rst_n && out_valid) begin
         if (req_q.size() == 0) begin
            n_errors++;
            $display("A result appeared at time %0t with no request outstanding", $time);
         end else begin
            r        = req_q.pop_front();
            t        = sent_q.pop_front();
            expected = fp_add_ref(r);
            check_value(r, res.value, expected.value);
            check_flags(r, res.flags, expected.flags);
            if (cycle - t != 2) begin
               n_errors++;
               $display("Result for %h and %h came %0d cycles after its request, not 2",
                        r.operand_a, r.operand_b, cycle - t);
            end
         end
      end
   end

   initial begin
      int          c0;
      int          e0;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] x;
      in_valid = 1'b0;
      req      = '0;
      rst_n    = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      rst_n = 1'b1;

      c0 = n_checks;
      e0 = n_errors;
      for (int i = 0; i < N_RAND; i++) begin
         x = lcg_next();
         send(fp_op_e'(x[31]), rand_frm(), rand_normal(100, 55), rand_normal(100, 55));
      end
      end_test("random", c0, e0);

      c0 = n_checks;
      e0 = n_errors;
      for (int i = 0; i < N_CANCEL; i++) begin
         a = rand_normal(120, 16);
         x = lcg_next();
         case (i % 4)
            0:       b = a ^ (x & 32'h0000_00FF);
            1:       b = a ^ (x & 32'h0000_FFFF);
            2:       b = (a - 32'h0080_0000) ^ (x & 32'h0000_0007);   // One exponent lower.
            default: b = a;
         endcase
         send(op_sub, round_mode_e'(3'(i % 5)), a, b);
      end
      end_test("cancellation", c0, e0);

      c0 = n_checks;
      e0 = n_errors;
      for (int i = 0; i < N_OVUF; i++) begin
         x = lcg_next();
         b = lcg_next();
         if (i < N_OVUF / 2) begin
            send(op_add, rand_frm(), {x[31], 8'd254, x[22:0]}, {x[31], 8'd254, b[22:0]});
         end else begin
            send(op_sub, rand_frm(), {x[31], 8'd1, x[22:0]}, {x[31], 8'd1, b[22:0]});
         end
      end
      end_test("overflow and underflow", c0, e0);

      c0 = n_checks;
      e0 = n_errors;
      send(op_add, rm_rne, `QNAN, 32'h3F80_0000);
      send(op_sub, rm_rtz, 32'h4000_0000, 32'h7F80_0001);   // Signalling NaN.
      send(op_add, rm_rup, 32'hFFFF_FFFF, 32'h7F80_0000);
      send(op_sub, rm_rne, 32'h7F80_0000, 32'h7F80_0000);
      send(op_add, rm_rdn, 32'hFF80_0000, 32'h7F80_0000);
      send(op_add, rm_rmm, 32'h7F80_0000, 32'hC2F6_0000);
      send(op_sub, rm_rne, 32'h4120_0000, 32'h7F80_0000);
      send(op_sub, rm_rup, 32'h7F80_0000, 32'hFF80_0000);
      end_test("nan and infinity", c0, e0);

      c0 = n_checks;
      e0 = n_errors;
      for (int i = 0; i < N_ZERO; i++) begin
         x = lcg_next();
         send(fp_op_e'(x[30]), rand_frm(), edge_operand(i[1:0]), edge_operand(i[3:2]));
      end
      end_test("zero and subnormal", c0, e0);

      c0 = n_checks;
      e0 = n_errors;
      for (int i = 0; i < N_BURST; i++) begin
         x = lcg_next();
         send(fp_op_e'(x[29]), rand_frm(), rand_normal(1, 253), rand_normal(1, 253));
      end
      end_test("back to back", c0, e0);

      if (n_checks != 2 * N_TOTAL) begin
         n_errors++;
         $display("Only %0d of %0d results were checked", n_checks / 2, N_TOTAL);
      end
      if (u_fp_add_unit.u_fp_add_checker.n_fail != 0) begin
         n_errors++;
         $display("The bound checker saw %0d assertion failures",
                  u_fp_add_unit.u_fp_add_checker.n_fail);
      end
      $display("Checks: %0d, errors: %0d", n_checks, n_errors);
      if (n_errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

//--- tb/tb_clock.sv
module tb_clock #(
   parameter int PERIOD = 8
) (
   output logic clk
);

   initial begin
      clk = 1'b0;
      forever begin
         #(PERIOD / 2) clk = ~clk;               // Half period high, half low.
      end
   end

endmodule
